// ==== list.f ====
+incdir+hdl
+incdir+tb
hdl/dma_pkg.sv
hdl/frame_sequencer.sv
hdl/axi_line_reader.sv
hdl/line_fifo.sv
hdl/axi_burst_writer.sv
hdl/frame_dma_top.sv
tb/tb_frame_dma.sv

// ==== Makefile ====
TOP := tb_frame_dma

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert --top-module $(TOP) -f list.f

# Pass only when the testbench prints its pass line
sim:
	verilator --binary --timing --assert -j 0 --top-module $(TOP) -f list.f -o sim_$(TOP)
	./obj_dir/sim_$(TOP) | tee /dev/stderr | grep -q "All checks passed"

clean:
	rm -rf obj_dir

// ==== tb/tb_tests.svh ====
// Four times the nominal cycle count of one frame
function automatic int frame_budget(input dma_pkg::frame_cfg_t cfg);
    return 4 * (int'(cfg.height) * (`DMA_HSYNC_DELAY + int'(cfg.width)) + `DMA_START_UP_DELAY);
endfunction

function automatic int total_errors();
    return err_cnt + mon_err;
endfunction

// ------------------------------
// Compare tasks
// ------------------------------
task automatic check_word(input dma_pkg::word_t got, input dma_pkg::word_t exp, input string what);
    check_cnt++;
    if (got !== exp) begin
        err_cnt++;
        $display("[ERROR] %0t %s got %h expected %h", $time, what, got, exp);
    end
endtask

task automatic check_addr(input dma_pkg::addr_t got, input dma_pkg::addr_t exp, input string what);
    check_cnt++;
    if (got !== exp) begin
        err_cnt++;
        $display("[ERROR] %0t %s got %h expected %h", $time, what, got, exp);
    end
endtask

task automatic check_len(input dma_pkg::burst_len_t got, input dma_pkg::burst_len_t exp,
                         input string what);
    check_cnt++;
    if (got !== exp) begin
        err_cnt++;
        $display("[ERROR] %0t %s got %0d expected %0d", $time, what, got, exp);
    end
endtask

task automatic check_bit(input logic got, input logic exp, input string what);
    check_cnt++;
    if (got !== exp) begin
        err_cnt++;
        $display("[ERROR] %0t %s got %b expected %b", $time, what, got, exp);
    end
endtask

task automatic close_test(input string name, input int err_before);
    test_cnt++;
    $display("%s finished with %0d errors", name, total_errors() - err_before);
endtask

// ------------------------------
// Frame driver and result checks
// ------------------------------
task automatic run_frame(input dma_pkg::frame_cfg_t cfg);
    int waited;
    ar_base = ar_addr_log.size();
    aw_base = aw_addr_log.size();
    @(posedge HCLK);
    #2;
    i_cfg      = cfg;
    i_ap_start = 1'b1;
    start_cyc  = cyc;
    @(posedge HCLK);
    #2;
    i_ap_start = 1'b0;                      // Config latched by now
    check_bit(o_ap_done, 1'b0, "o_ap_done cleared by start");
    check_bit(o_ap_idle, 1'b0, "o_ap_idle dropped by start");
    b_base       = b_total;
    frame_height = int'(cfg.height);
    frame_on     = 1'b1;
    waited       = 0;
    while (!o_ap_done && waited < frame_budget(cfg)) begin
        @(posedge HCLK);
        #2;
        waited++;
    end
    frame_on = 1'b0;
    if (!o_ap_done) begin
        err_cnt++;
        $display("Timed out waiting for o_ap_done after %0d cycles", waited);
    end
endtask

// Lines step by the width and form one contiguous block
task automatic verify_copy(input dma_pkg::frame_cfg_t cfg);
    int             words;
    dma_pkg::addr_t src;
    dma_pkg::addr_t dst;
    words = int'(cfg.height) * int'(cfg.width) / 4;
    for (int k = 0; k < words; k++) begin
        src = cfg.rd_base + dma_pkg::addr_t'(4 * k);
        dst = cfg.wr_base + dma_pkg::addr_t'(4 * k);
        check_word(dst_mem[dst[13:2]], src_mem[src[13:2]], $sformatf("copied word %0d", k));
    end
endtask

task automatic compare_burst_logs(input dma_pkg::frame_cfg_t cfg);
    dma_pkg::burst_len_t len;
    dma_pkg::addr_t      step;
    len = dma_pkg::burst_len_t'(int'(cfg.width) / 4 - 1);     // Words per line less one
    check_bit(ar_addr_log.size() - ar_base == int'(cfg.height), 1'b1, "AR burst count");
    check_bit(aw_addr_log.size() - aw_base == int'(cfg.height), 1'b1, "AW burst count");
    for (int i = 0; i < ar_addr_log.size() - ar_base; i++) begin
        step = dma_pkg::addr_t'(i) * dma_pkg::addr_t'(cfg.width);
        check_addr(ar_addr_log[ar_base + i], cfg.rd_base + step, $sformatf("AR addr line %0d", i));
        check_len(ar_len_log[ar_base + i], len, $sformatf("AR len line %0d", i));
    end
    for (int i = 0; i < aw_addr_log.size() - aw_base; i++) begin
        step = dma_pkg::addr_t'(i) * dma_pkg::addr_t'(cfg.width);
        check_addr(aw_addr_log[aw_base + i], cfg.wr_base + step, $sformatf("AW addr line %0d", i));
        check_len(aw_len_log[aw_base + i], len, $sformatf("AW len line %0d", i));
    end
endtask

// ------------------------------
// Directed tests
// ------------------------------
task automatic reset_outputs();
    int e;
    e = total_errors();
    check_bit(o_arvalid, 1'b0, "o_arvalid after reset");
    check_bit(o_awvalid, 1'b0, "o_awvalid after reset");
    check_bit(o_wvalid, 1'b0, "o_wvalid after reset");
    check_bit(o_ap_done, 1'b0, "o_ap_done after reset");
    check_bit(o_ap_idle, 1'b1, "o_ap_idle after reset");
    check_bit(o_rready, 1'b1, "o_rready after reset");
    check_bit(o_bready, 1'b1, "o_bready after reset");
    close_test("reset_outputs", e);
endtask

task automatic plain_frame_copy();
    int e;
    e = total_errors();
    run_frame(frame_a);
    check_bit(o_ap_done, 1'b1, "o_ap_done at frame end");
    verify_copy(frame_a);
    close_test("plain_frame_copy", e);
endtask

task automatic burst_log_contents();
    int e;
    e = total_errors();
    compare_burst_logs(frame_a);            // Logs of the frame just copied
    close_test("burst_log_contents", e);
endtask

task automatic start_and_gap_timing();
    int e;
    int gap;
    e = total_errors();
    if (ar_cyc_log.size() <= ar_base) begin
        err_cnt++;
        $display("No AR valid was seen after the start");
    end else begin
        gap = ar_cyc_log[ar_base] - start_cyc;
        check_bit(gap == `DMA_START_UP_DELAY + 1, 1'b1,
                  $sformatf("first AR valid %0d cycles after start", gap));
        for (int i = ar_base + 1; i < ar_cyc_log.size(); i++) begin
            gap = ar_cyc_log[i] - ar_cyc_log[i - 1];
            check_bit(gap >= `DMA_HSYNC_DELAY, 1'b1, $sformatf("AR valid spacing %0d", gap));
        end
    end
    close_test("start_and_gap_timing", e);
endtask

task automatic stalled_frame_copy();
    int e;
    e = total_errors();
    stall = 1'b1;
    run_frame(frame_b);
    stall = 1'b0;
    check_bit(o_ap_done, 1'b1, "o_ap_done at stalled frame end");
    verify_copy(frame_b);
    compare_burst_logs(frame_b);
    close_test("stalled_frame_copy", e);
endtask

// Done and idle flags on a second start are checked inside run_frame
task automatic restart_frame();
    int e;
    e = total_errors();
    check_bit(o_ap_done, 1'b1, "o_ap_done held before restart");
    run_frame(frame_c);
    check_bit(o_ap_done, 1'b1, "o_ap_done after restart");
    check_bit(o_ap_idle, 1'b1, "o_ap_idle after restart");
    verify_copy(frame_c);
    close_test("restart_frame", e);
endtask

// ==== tb/tb_frame_dma.sv ====
`include "dma_defines.svh"

module tb_frame_dma;

    // Frame setups as rd_base, wr_base, width, height
    localparam dma_pkg::frame_cfg_t frame_a = '{32'h0000_0100, 32'h0000_2000, 12'd16, 12'd4};
    localparam dma_pkg::frame_cfg_t frame_b = '{32'h0000_0400, 32'h0000_2800, 12'd64, 12'd6};
    localparam dma_pkg::frame_cfg_t frame_c = '{32'h0000_0a00, 32'h0000_3000, 12'd32, 12'd3};

    logic                HCLK = 1'b0;
    logic                HRESETn = 1'b0;
    logic                i_ap_start = 1'b0;
    dma_pkg::frame_cfg_t i_cfg = '0;
    logic                o_ap_done;
    logic                o_ap_idle;
    dma_pkg::axi_ar_t    o_ar;
    logic                o_arvalid;
    logic                i_arready = 1'b0;
    dma_pkg::axi_r_t     i_r = '0;
    logic                i_rvalid = 1'b0;
    logic                o_rready;
    dma_pkg::axi_aw_t    o_aw;
    logic                o_awvalid;
    logic                i_awready = 1'b0;
    dma_pkg::axi_w_t     o_w;
    logic                o_wvalid;
    logic                i_wready = 1'b0;
    logic                i_bvalid = 1'b0;
    logic                o_bready;

    dma_pkg::word_t      src_mem [4096];     // Word index is addr[13:2]
    dma_pkg::word_t      dst_mem [4096];
    integer              seed = 32'h7054_a61a;
    logic                stall = 1'b0;       // Random gaps on every channel
    int                  cyc = 0;
    int                  err_cnt = 0;        // From the test tasks
    int                  mon_err = 0;        // From the slave models
    int                  check_cnt = 0;
    int                  test_cnt = 0;

    // ------------------------------
    // Slave model and monitor state
    // ------------------------------
    dma_pkg::axi_ar_t    rd_q [$];           // Accepted AR, not yet answered
    dma_pkg::addr_t      rd_addr = '0;
    int                  rd_left = 0;        // Beats left in current burst
    dma_pkg::addr_t      wr_q [$];           // Next W address per open burst
    int                  b_pend = 0;
    int                  b_total = 0;        // All B handshakes so far
    int                  b_base = 0;
    logic                frame_on = 1'b0;
    int                  frame_height = 0;
    int                  start_cyc = 0;
    int                  ar_base = 0;        // Log index of this frame
    int                  aw_base = 0;
    dma_pkg::addr_t      ar_addr_log [$];
    dma_pkg::burst_len_t ar_len_log [$];
    int                  ar_cyc_log [$];     // Cycle of each AR valid rise
    logic                ar_seen = 1'b0;
    dma_pkg::addr_t      aw_addr_log [$];
    dma_pkg::burst_len_t aw_len_log [$];

    frame_dma_top u_dut (.*);

    always #20 HCLK = ~HCLK;

    always @(posedge HCLK) cyc <= cyc + 1;

    // Three in four cycles go ahead while stalling
    function automatic logic channel_go();
        return !stall || (($random(seed) & 3) != 0);
    endfunction

    always @(posedge HCLK) begin : axi_monitors
        if (o_arvalid && !ar_seen) ar_cyc_log.push_back(cyc);
        ar_seen <= o_arvalid && !i_arready;
        if (o_arvalid && i_arready) begin
            ar_addr_log.push_back(o_ar.addr);
            ar_len_log.push_back(o_ar.len);
        end
        if (o_awvalid && i_awready) begin
            aw_addr_log.push_back(o_aw.addr);
            aw_len_log.push_back(o_aw.len);
        end
    end

    // ------------------------------
    // AXI slave memory models
    // ------------------------------
    always @(posedge HCLK) begin : axi_slaves
        logic           in_reset;
        logic           r_hold;
        logic           b_hold;
        dma_pkg::addr_t wa;
        in_reset = !HRESETn;
        r_hold   = i_rvalid && !o_rready;       // Unaccepted beat stays put
        b_hold   = i_bvalid && !o_bready;
        if (in_reset) begin
            rd_q.delete();
            wr_q.delete();
            rd_left = 0;
            b_pend  = 0;
        end else begin
            if (frame_on && o_ap_done && (b_total - b_base) < frame_height) begin
                mon_err++;
                $display("[ERROR] %0t o_ap_done high after only %0d of %0d write responses",
                         $time, b_total - b_base, frame_height);
            end
            if (o_arvalid && i_arready) rd_q.push_back(o_ar);
            if (i_rvalid && o_rready) begin
                rd_addr += 4;
                rd_left--;
            end
            if (rd_left == 0 && rd_q.size() != 0) begin      // Next read burst
                rd_addr = rd_q[0].addr;
                rd_left = int'(rd_q[0].len) + 1;
                void'(rd_q.pop_front());
            end
            if (o_awvalid && i_awready) wr_q.push_back(o_aw.addr);
            if (o_wvalid && i_wready) begin
                if (wr_q.size() == 0) begin
                    mon_err++;
                    $display("W beat arrived with no open write burst at %0t", $time);
                end else begin
                    wa = wr_q[0];
                    dst_mem[wa[13:2]] = o_w.data;
                    wr_q[0] = wa + 4;
                    if (o_w.last) begin
                        void'(wr_q.pop_front());
                        b_pend++;
                    end
                end
            end
            if (i_bvalid && o_bready) begin
                b_pend--;
                b_total++;
            end
        end
        #2;
        i_arready = !in_reset && channel_go();
        i_awready = !in_reset && channel_go();
        i_wready  = !in_reset && channel_go();
        if (!r_hold) i_rvalid = !in_reset && rd_left > 0 && channel_go();
        i_r.data  = src_mem[rd_addr[13:2]];
        i_r.last  = (rd_left == 1);
        if (!b_hold) i_bvalid = !in_reset && b_pend > 0 && channel_go();
    end

    `include "tb_tests.svh"

    initial begin : main
        int i;
        for (i = 0; i < 4096; i++) begin
            src_mem[i] = $random(seed);
            dst_mem[i] = dma_pkg::word_t'(32'hd5d5_0000 ^ i);    // Stale marker
        end
        repeat (10) @(posedge HCLK);
        #2;
        HRESETn = 1'b1;
        reset_outputs();
        plain_frame_copy();
        burst_log_contents();
        start_and_gap_timing();
        stalled_frame_copy();
        restart_frame();
        repeat (5) @(posedge HCLK);
        $display("Summary %0d tests, %0d checks, %0d errors", test_cnt, check_cnt,
                 total_errors());
        if (total_errors() == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

    // Watchdog over the summed frame budgets
    initial begin : watchdog
        int wd_cycles;
        wd_cycles = frame_budget(frame_a) + frame_budget(frame_b) + frame_budget(frame_c);
        #(40 * wd_cycles);
        $display("Watchdog expired before the tests finished");
        $display("Checks failed");
        $finish;
    end

endmodule

// ==== hdl/frame_dma_top.sv ====
`include "dma_defines.svh"

module frame_dma_top (
    input  logic                HCLK,
    input  logic                HRESETn,
    // Control
    input  logic                i_ap_start,
    input  dma_pkg::frame_cfg_t i_cfg,
    output logic                o_ap_done,
    output logic                o_ap_idle,
    // AXI read
    output dma_pkg::axi_ar_t    o_ar,
    output logic                o_arvalid,
    input  logic                i_arready,
    input  dma_pkg::axi_r_t     i_r,
    input  logic                i_rvalid,
    output logic                o_rready,
    // AXI write
    output dma_pkg::axi_aw_t    o_aw,
    output logic                o_awvalid,
    input  logic                i_awready,
    output dma_pkg::axi_w_t     o_w,
    output logic                o_wvalid,
    input  logic                i_wready,
    input  logic                i_bvalid,
    output logic                o_bready
);

    dma_pkg::frame_cfg_t cfg;           // Latched frame setup
    logic                frame_go;
    logic                frame_done;
    logic                line_req;
    dma_pkg::addr_t      line_addr;
    logic                rd_busy;
    logic                push;
    dma_pkg::word_t      push_data;
    logic                pop;
    dma_pkg::word_t      pop_data;
    dma_pkg::fifo_cnt_t  count;
    dma_pkg::fifo_cnt_t  free;
    logic                full;

    frame_sequencer u_seq (
        .HCLK, .HRESETn, .i_ap_start, .i_cfg,
        .i_rd_busy(rd_busy), .i_fifo_free(free), .i_frame_done(frame_done),
        .o_cfg(cfg), .o_frame_go(frame_go), .o_line_req(line_req),
        .o_line_addr(line_addr), .o_ap_done, .o_ap_idle
    );

    axi_line_reader u_rd (
        .HCLK, .HRESETn, .i_line_req(line_req), .i_line_addr(line_addr),
        .i_width(cfg.width), .i_arready, .i_r, .i_rvalid, .i_fifo_full(full),
        .o_ar, .o_arvalid, .o_rready, .o_push(push), .o_push_data(push_data),
        .o_busy(rd_busy)
    );

    // Writer gates W on the count
    line_fifo u_fifo (
        .HCLK, .HRESETn, .i_push(push), .i_push_data(push_data), .i_pop(pop),
        .o_pop_data(pop_data), .o_count(count), .o_free(free),
        .o_full(full), .o_empty()
    );

    axi_burst_writer u_wr (
        .HCLK, .HRESETn, .i_cfg(cfg), .i_frame_go(frame_go),
        .i_fifo_count(count), .i_fifo_data(pop_data), .i_awready, .i_wready,
        .i_bvalid, .o_pop(pop), .o_aw, .o_awvalid, .o_w, .o_wvalid, .o_bready,
        .o_frame_done(frame_done)
    );

endmodule

// ==== hdl/axi_burst_writer.sv ====
`include "dma_defines.svh"

module axi_burst_writer (
    input  logic                HCLK,
    input  logic                HRESETn,
    input  dma_pkg::frame_cfg_t i_cfg,
    input  logic                i_frame_go,
    input  dma_pkg::fifo_cnt_t  i_fifo_count,
    input  dma_pkg::word_t      i_fifo_data,
    input  logic                i_awready,
    input  logic                i_wready,
    input  logic                i_bvalid,
    output logic                o_pop,
    output dma_pkg::axi_aw_t    o_aw,
    output logic                o_awvalid,
    output dma_pkg::axi_w_t     o_w,
    output logic                o_wvalid,
    output logic                o_bready,
    output logic                o_frame_done
);

    dma_pkg::wr_state_t   state;
    logic                 active;       // Frame in progress
    dma_pkg::dim_t        line_idx;
    dma_pkg::addr_t       line_addr;    // Next AW address
    dma_pkg::burst_len_t  beat_cnt;
    dma_pkg::fifo_cnt_t   line_words;

    assign line_words = dma_pkg::fifo_cnt_t'(i_cfg.width >> 2);
    assign o_awvalid  = (state == dma_pkg::WR_ADDR);
    assign o_wvalid   = (state == dma_pkg::WR_DATA) && (i_fifo_count != '0);
    assign o_w.data   = i_fifo_data;              // FIFO head, no extra stage
    assign o_w.last   = (beat_cnt == o_aw.len);
    assign o_pop      = o_wvalid && i_wready;
    assign o_bready   = (state == dma_pkg::WR_IDLE) || (state == dma_pkg::WR_RESP);

    // AW payload
    always_ff @(posedge HCLK) begin
        if (state == dma_pkg::WR_IDLE) begin
            o_aw.addr <= line_addr;
            o_aw.len  <= dma_pkg::burst_len_t'(line_words - 1'b1);
        end
    end

    // ------------------------------
    // Write FSM
    // ------------------------------
    always_ff @(posedge HCLK or negedge HRESETn) begin
        if (!HRESETn) begin
            state        <= dma_pkg::WR_IDLE;
            active       <= 1'b0;
            line_idx     <= '0;
            line_addr    <= '0;
            beat_cnt     <= '0;
            o_frame_done <= 1'b0;
        end else begin
            o_frame_done <= 1'b0;
            if (i_frame_go) begin
                active    <= 1'b1;
                line_idx  <= '0;
                line_addr <= i_cfg.wr_base;
            end
            case (state)
                dma_pkg::WR_IDLE: begin
                    // Whole line buffered
                    if (active && i_fifo_count >= line_words) state <= dma_pkg::WR_ADDR;
                end
                dma_pkg::WR_ADDR: begin
                    if (i_awready) begin
                        state    <= dma_pkg::WR_DATA;
                        beat_cnt <= '0;
                    end
                end
                dma_pkg::WR_DATA: begin
                    if (o_pop) begin
                        beat_cnt <= beat_cnt + 1'b1;
                        if (o_w.last) state <= dma_pkg::WR_RESP;
                    end
                end
                dma_pkg::WR_RESP: begin
                    if (i_bvalid) begin         // Response assumed OKAY
                        state <= dma_pkg::WR_IDLE;
                        if (line_idx == i_cfg.height - 1'b1) begin
                            active       <= 1'b0;
                            o_frame_done <= 1'b1;
                        end else begin
                            line_idx  <= line_idx + 1'b1;
                            line_addr <= line_addr + dma_pkg::addr_t'(i_cfg.width);
                        end
                    end
                end
                default: state <= dma_pkg::WR_IDLE;
            endcase
        end
    end

    // Stalled W beat holds its payload and stays in the data phase
    a_w_hold: assert property (@(posedge HCLK) disable iff (!HRESETn)
        (o_wvalid && !i_wready) |=>
            (o_wvalid && $stable(o_w) && state == dma_pkg::WR_DATA));

endmodule

// ==== hdl/line_fifo.sv ====
`include "dma_defines.svh"

module line_fifo (
    input  logic               HCLK,
    input  logic               HRESETn,
    input  logic               i_push,
    input  dma_pkg::word_t     i_push_data,
    input  logic               i_pop,
    output dma_pkg::word_t     o_pop_data,
    output dma_pkg::fifo_cnt_t o_count,
    output dma_pkg::fifo_cnt_t o_free,
    output logic               o_full,
    output logic               o_empty
);

    dma_pkg::word_t             mem [`DMA_FIFO_DEPTH];
    logic [`DMA_FIFO_CNT_W-2:0] wr_ptr;     // Wraps at depth
    logic [`DMA_FIFO_CNT_W-2:0] rd_ptr;

    // Head word shows without a pop
    assign o_pop_data = mem[rd_ptr];
    assign o_full     = (o_count == dma_pkg::fifo_cnt_t'(`DMA_FIFO_DEPTH));
    assign o_empty    = (o_count == '0);
    assign o_free     = dma_pkg::fifo_cnt_t'(`DMA_FIFO_DEPTH) - o_count;

    always_ff @(posedge HCLK) begin
        if (i_push) mem[wr_ptr] <= i_push_data;
    end

    // ------------------------------
    // Pointers and fill count
    // ------------------------------
    always_ff @(posedge HCLK or negedge HRESETn) begin
        if (!HRESETn) begin
            wr_ptr  <= '0;
            rd_ptr  <= '0;
            o_count <= '0;
        end else begin
            if (i_push) wr_ptr <= wr_ptr + 1'b1;
            if (i_pop) rd_ptr <= rd_ptr + 1'b1;
            case ({i_push, i_pop})
                2'b10:   o_count <= o_count + 1'b1;
                2'b01:   o_count <= o_count - 1'b1;
                default: o_count <= o_count;    // Both or neither
            endcase
        end
    end

    // Reader and writer handshakes keep these apart
    a_no_overflow: assert property (@(posedge HCLK) disable iff (!HRESETn)
        i_push |-> !o_full);
    a_no_underflow: assert property (@(posedge HCLK) disable iff (!HRESETn)
        i_pop |-> !o_empty);

endmodule

// ==== hdl/axi_line_reader.sv ====
`include "dma_defines.svh"

module axi_line_reader (
    input  logic              HCLK,
    input  logic              HRESETn,
    input  logic              i_line_req,
    input  dma_pkg::addr_t    i_line_addr,
    input  dma_pkg::dim_t     i_width,
    input  logic              i_arready,
    input  dma_pkg::axi_r_t   i_r,
    input  logic              i_rvalid,
    input  logic              i_fifo_full,
    output dma_pkg::axi_ar_t  o_ar,
    output logic              o_arvalid,
    output logic              o_rready,
    output logic              o_push,
    output dma_pkg::word_t    o_push_data,
    output logic              o_busy
);

    dma_pkg::rd_state_t   state;
    dma_pkg::burst_len_t  beat_cnt;     // Beats taken in this burst
    logic                 r_fire;

    assign o_arvalid   = (state == dma_pkg::RD_ADDR);
    assign o_rready    = !i_fifo_full;   // Stall R on a full FIFO
    assign r_fire      = i_rvalid && o_rready;
    assign o_push      = r_fire;         // Loopback into the line FIFO
    assign o_push_data = i_r.data;
    assign o_busy      = (state != dma_pkg::RD_IDLE);

    // AR payload, stable while valid
    always_ff @(posedge HCLK) begin
        if (i_line_req && state == dma_pkg::RD_IDLE) begin
            o_ar.addr <= i_line_addr;
            // One word per four pixels
            o_ar.len  <= dma_pkg::burst_len_t'((i_width >> 2) - 1'b1);
        end
    end

    // ------------------------------
    // Read FSM
    // ------------------------------
    always_ff @(posedge HCLK or negedge HRESETn) begin
        if (!HRESETn) begin
            state    <= dma_pkg::RD_IDLE;
            beat_cnt <= '0;
        end else begin
            case (state)
                dma_pkg::RD_IDLE: begin
                    if (i_line_req) state <= dma_pkg::RD_ADDR;
                end
                dma_pkg::RD_ADDR: begin
                    if (i_arready) begin        // Address accepted
                        state    <= dma_pkg::RD_DATA;
                        beat_cnt <= '0;
                    end
                end
                dma_pkg::RD_DATA: begin
                    if (r_fire) begin
                        beat_cnt <= beat_cnt + 1'b1;
                        if (i_r.last) state <= dma_pkg::RD_IDLE;
                    end
                end
                default: state <= dma_pkg::RD_IDLE;
            endcase
        end
    end

    // Slave burst length must match the AR len
    a_rlast_pos: assert property (@(posedge HCLK) disable iff (!HRESETn)
        (r_fire && state == dma_pkg::RD_DATA) |-> (i_r.last == (beat_cnt == o_ar.len)));

endmodule

// ==== hdl/frame_sequencer.sv ====
`include "dma_defines.svh"

module frame_sequencer (
    input  logic                HCLK,
    input  logic                HRESETn,
    input  logic                i_ap_start,
    input  dma_pkg::frame_cfg_t i_cfg,
    input  logic                i_rd_busy,
    input  dma_pkg::fifo_cnt_t  i_fifo_free,
    input  logic                i_frame_done,
    output dma_pkg::frame_cfg_t o_cfg,
    output logic                o_frame_go,
    output logic                o_line_req,
    output dma_pkg::addr_t      o_line_addr,
    output logic                o_ap_done,
    output logic                o_ap_idle
);

    dma_pkg::seq_state_t state;
    logic                start_d;       // Previous i_ap_start
    logic                start_edge;
    logic                accept;        // Edge taken only when idle
    logic [7:0]          dly_cnt;       // Startup and line gap timer
    dma_pkg::dim_t       line_cnt;      // Requests issued so far
    dma_pkg::fifo_cnt_t  line_words;

    assign start_edge = i_ap_start && !start_d;
    assign accept     = start_edge && (state == dma_pkg::SEQ_IDLE);
    assign line_words = dma_pkg::fifo_cnt_t'(o_cfg.width >> 2);
    assign o_ap_idle  = (state == dma_pkg::SEQ_IDLE);

    // Reader free and a whole line of FIFO space
    assign o_line_req = (state == dma_pkg::SEQ_REQ) && !i_rd_busy &&
                        (i_fifo_free >= line_words);

    // Config holds for the whole frame
    always_ff @(posedge HCLK) begin
        if (accept) o_cfg <= i_cfg;
    end

    // ------------------------------
    // Frame FSM
    // ------------------------------
    always_ff @(posedge HCLK or negedge HRESETn) begin
        if (!HRESETn) begin
            state       <= dma_pkg::SEQ_IDLE;
            start_d     <= 1'b0;
            dly_cnt     <= '0;
            line_cnt    <= '0;
            o_line_addr <= '0;
            o_frame_go  <= 1'b0;
            o_ap_done   <= 1'b0;
        end else begin
            start_d    <= i_ap_start;
            o_frame_go <= accept;           // Writer sees latched cfg
            case (state)
                dma_pkg::SEQ_IDLE: begin
                    if (accept) begin
                        state       <= dma_pkg::SEQ_STARTUP;
                        dly_cnt     <= '0;
                        line_cnt    <= '0;
                        o_line_addr <= i_cfg.rd_base;
                        o_ap_done   <= 1'b0;
                    end
                end
                dma_pkg::SEQ_STARTUP: begin
                    dly_cnt <= dly_cnt + 8'd1;
                    // Request lands START_UP_DELAY-1 cycles after latch
                    if (dly_cnt == 8'(`DMA_START_UP_DELAY - 2)) state <= dma_pkg::SEQ_REQ;
                end
                dma_pkg::SEQ_GAP: begin
                    dly_cnt <= dly_cnt + 8'd1;
                    if (dly_cnt == 8'(`DMA_HSYNC_DELAY - 2)) state <= dma_pkg::SEQ_REQ;
                end
                dma_pkg::SEQ_REQ: begin
                    if (o_line_req) begin
                        o_line_addr <= o_line_addr + dma_pkg::addr_t'(o_cfg.width);
                        line_cnt    <= line_cnt + 1'b1;
                        dly_cnt     <= '0;
                        if (line_cnt == o_cfg.height - 1'b1) begin
                            state <= dma_pkg::SEQ_DRAIN;    // Last line issued
                        end else begin
                            state <= dma_pkg::SEQ_GAP;
                        end
                    end
                end
                dma_pkg::SEQ_DRAIN: begin
                    if (i_frame_done) begin         // Final B seen by writer
                        o_ap_done <= 1'b1;
                        state     <= dma_pkg::SEQ_IDLE;
                    end
                end
                default: state <= dma_pkg::SEQ_IDLE;
            endcase
        end
    end

    // Writer can only finish once the last line was requested
    a_done_in_drain: assert property (@(posedge HCLK) disable iff (!HRESETn)
        i_frame_done |-> (state == dma_pkg::SEQ_DRAIN));

endmodule

// ==== hdl/dma_pkg.sv ====
`include "dma_defines.svh"

package dma_pkg;

    // ------------------------------
    // Vector types
    // ------------------------------
    typedef logic [`DMA_ADDR_W-1:0]     addr_t;         // Byte address
    typedef logic [`DMA_DATA_W-1:0]     word_t;         // Four pixels
    typedef logic [`DMA_DIM_W-1:0]      dim_t;          // Pixel or line count
    typedef logic [`DMA_LEN_W-1:0]      burst_len_t;    // Beats minus one
    typedef logic [`DMA_FIFO_CNT_W-1:0] fifo_cnt_t;     // FIFO occupancy

    // Frame setup, latched on start
    typedef struct packed {
        addr_t rd_base;
        addr_t wr_base;
        dim_t  width;       // Pixels, multiple of 4
        dim_t  height;      // Lines
    } frame_cfg_t;

    // ------------------------------
    // AXI channel payloads
    // ------------------------------
    typedef struct packed {
        addr_t      addr;
        burst_len_t len;
    } axi_ar_t;

    typedef struct packed {
        word_t data;
        logic  last;
    } axi_r_t;

    typedef struct packed {
        addr_t      addr;
        burst_len_t len;
    } axi_aw_t;

    typedef struct packed {
        word_t data;
        logic  last;
    } axi_w_t;

    // FSM encodings
    typedef enum logic [2:0] {
        SEQ_IDLE, SEQ_STARTUP, SEQ_GAP, SEQ_REQ, SEQ_DRAIN
    } seq_state_t;

    typedef enum logic [1:0] {RD_IDLE, RD_ADDR, RD_DATA} rd_state_t;

    typedef enum logic [1:0] {WR_IDLE, WR_ADDR, WR_DATA, WR_RESP} wr_state_t;

endpackage

// ==== hdl/dma_defines.svh ====
`ifndef DMA_DEFINES_SVH
`define DMA_DEFINES_SVH

// ------------------------------
// Bus widths
// ------------------------------
`define DMA_ADDR_W 32           // Byte address
`define DMA_DATA_W 32           // Four 8-bit pixels per word
`define DMA_DIM_W 12            // Width and height fields
`define DMA_LEN_W 8             // AXI len, beats minus one

// ------------------------------
// Timing
// ------------------------------
// Start latch to first AR valid
`define DMA_START_UP_DELAY 200
// Minimum spacing of line requests
`define DMA_HSYNC_DELAY 160

// ------------------------------
// Line FIFO
// ------------------------------
`define DMA_FIFO_DEPTH 512      // Words, room for two max lines
`define DMA_FIFO_CNT_W 10       // Holds 0..DEPTH

`endif
